//--- rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  // register and pc width
  localparam int xlen = 32;
  // register index width
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes of the supported instructions
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;

  // funct3 shared by addi, add and sub
  localparam logic [2:0] funct3_add = 3'b000;
  // funct7 that turns add into sub
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // what occupies a stage in a given cycle
  typedef enum logic [1:0] {
    cycle_invalid = 2'd0,
    cycle_reset = 2'd1,
    cycle_no_stall = 2'd2
  } cycle_status_e;

  // operation chosen in decode, carried into execute
  typedef enum logic [1:0] {
    alu_none = 2'd0,
    alu_lui = 2'd1,
    alu_add = 2'd2,
    alu_sub = 2'd3
  } alu_op_e;

  // state at the start of decode
  typedef struct packed {
    word_t pc;
    word_t insn;
    cycle_status_e status;
  } dec_stage_t;

  // state at the start of execute
  typedef struct packed {
    word_t pc;
    word_t insn;
    cycle_status_e status;
    alu_op_e alu_op;
    reg_addr_t rd;
    logic rd_we;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t rs1_data;
    word_t rs2_data;
    word_t imm;
  } exe_stage_t;

  // state at the start of memory, also the first bypass source
  typedef struct packed {
    word_t pc;
    word_t insn;
    cycle_status_e status;
    reg_addr_t rd;
    logic rd_we;
    word_t result;
  } mem_stage_t;

  // register write from writeback
  typedef struct packed {
    logic rd_we;
    reg_addr_t rd;
    word_t data;
  } wb_write_t;

  // what the retiring slot reports
  typedef struct packed {
    word_t pc;
    word_t insn;
    cycle_status_e status;
  } retire_trace_t;

endpackage

`default_nettype wire

//--- rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch
  import rv_pipe_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  wire        clk,
  input  wire        rst,
  input  word_t      insn_i,
  output word_t      pc_o,
  output dec_stage_t dec_o
);

  word_t pc_q;

  // pc register, no branches so it only ever steps by one word
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= reset_pc;
    end else begin
      pc_q <= pc_q + word_t'(4);
    end
  end

  // the instruction memory answers within the cycle
  assign pc_o = pc_q;

  // decode-stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      // reset bubble travels down the pipe from here
      dec_o <= '{pc: '0, insn: '0, status: cycle_reset};
    end else begin
      dec_o <= '{pc: pc_q, insn: insn_i, status: cycle_no_stall};
    end
  end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile
  import rv_pipe_pkg::*;
(
  input  wire       clk,
  input  wire       rst,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  input  wb_write_t wr_i
);

  // x0 has no storage
  word_t regs_q [1:31];

  // decode never raises rd_we for x0, so the write is unguarded
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.rd_we) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  // read port 1
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (wr_i.rd_we && wr_i.rd == rs1_i) begin
      // same-cycle write passes straight through
      rs1_data_o = wr_i.data;
    end else begin
      rs1_data_o = regs_q[rs1_i];
    end
  end

  // read port 2, same rules
  always_comb begin
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else if (wr_i.rd_we && wr_i.rd == rs2_i) begin
      rs2_data_o = wr_i.data;
    end else begin
      rs2_data_o = regs_q[rs2_i];
    end
  end

endmodule

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode
  import rv_pipe_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  dec_stage_t dec_i,
  output reg_addr_t  rs1_o,
  output reg_addr_t  rs2_o,
  input  word_t      rs1_data_i,
  input  word_t      rs2_data_i,
  output exe_stage_t exe_o
);

  // instruction fields, r-type layout
  logic [6:0] funct7;
  reg_addr_t  rs2;
  reg_addr_t  rs1;
  logic [2:0] funct3;
  reg_addr_t  rd;
  logic [6:0] opcode;

  word_t   imm_i;
  word_t   imm_u;
  word_t   imm;
  alu_op_e alu_op;
  logic    rd_we;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = dec_i.insn;

  // i-type immediate, sign extended from bit 31
  assign imm_i = {{20{dec_i.insn[31]}}, dec_i.insn[31:20]};
  // u-type immediate, upper 20 bits
  assign imm_u = {dec_i.insn[31:12], 12'b0};
  assign imm = (opcode == op_lui) ? imm_u : imm_i;

  // source indices go straight to the register file
  assign rs1_o = rs1;
  assign rs2_o = rs2;

  // classify, anything unknown becomes alu_none
  always_comb begin
    alu_op = alu_none;
    case (opcode)
      op_lui: begin
        alu_op = alu_lui;
      end
      op_reg_imm: begin
        // addi only
        if (funct3 == funct3_add) begin
          alu_op = alu_add;
        end
      end
      op_reg_reg: begin
        if (funct3 == funct3_add && funct7 == 7'b0) begin
          alu_op = alu_add;
        end else if (funct3 == funct3_add && funct7 == funct7_sub) begin
          alu_op = alu_sub;
        end
      end
      default: begin
        alu_op = alu_none;
      end
    endcase
  end

  // x0 is never written, bypass relies on this
  assign rd_we = (alu_op != alu_none) && (rd != '0);

  // execute-stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      exe_o <= '0;
      exe_o.status <= cycle_reset;
    end else begin
      exe_o <= '{
        pc: dec_i.pc,
        insn: dec_i.insn,
        status: dec_i.status,
        alu_op: alu_op,
        rd: rd,
        rd_we: rd_we,
        rs1: rs1,
        rs2: rs2,
        rs1_data: rs1_data_i,
        rs2_data: rs2_data_i,
        imm: imm
      };
    end
  end

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute
  import rv_pipe_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  exe_stage_t exe_i,
  input  wb_write_t  wb_i,
  output mem_stage_t mem_o
);

  word_t rs1_val;
  word_t rs2_val;
  word_t op_b;
  word_t result;

  // rs1 bypass, youngest producer wins
  always_comb begin
    if (mem_o.rd_we && mem_o.rd == exe_i.rs1) begin
      // producer one ahead, now in memory
      rs1_val = mem_o.result;
    end else if (wb_i.rd_we && wb_i.rd == exe_i.rs1) begin
      // producer two ahead, now in writeback
      rs1_val = wb_i.data;
    end else begin
      // older producers already reached the register file
      rs1_val = exe_i.rs1_data;
    end
  end

  // rs2 bypass, same priority
  always_comb begin
    if (mem_o.rd_we && mem_o.rd == exe_i.rs2) begin
      rs2_val = mem_o.result;
    end else if (wb_i.rd_we && wb_i.rd == exe_i.rs2) begin
      rs2_val = wb_i.data;
    end else begin
      rs2_val = exe_i.rs2_data;
    end
  end

  // addi takes the immediate, add and sub take rs2
  assign op_b = (exe_i.insn[6:0] == op_reg_reg) ? rs2_val : exe_i.imm;

  // alu
  always_comb begin
    case (exe_i.alu_op)
      alu_lui: begin
        // immediate already shifted in decode
        result = exe_i.imm;
      end
      alu_add: begin
        result = rs1_val + op_b;
      end
      alu_sub: begin
        result = rs1_val - op_b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // memory-stage register, also read back above for bypass
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_o <= '0;
      mem_o.status <= cycle_reset;
    end else begin
      mem_o <= '{
        pc: exe_i.pc,
        insn: exe_i.insn,
        status: exe_i.status,
        rd: exe_i.rd,
        rd_we: exe_i.rd_we,
        result: result
      };
    end
  end

endmodule

`default_nettype wire

//--- rv_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module rv_writeback
  import rv_pipe_pkg::*;
(
  input  wire           clk,
  input  wire           rst,
  input  mem_stage_t    mem_i,
  output wb_write_t     wr_o,
  output retire_trace_t trace_o
);

  // the memory stage does no work, its state moves on unchanged
  mem_stage_t wb_q;

  // writeback-stage register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= '0;
      wb_q.status <= cycle_reset;
    end else begin
      wb_q <= mem_i;
    end
  end

  // register write, also the second bypass source
  assign wr_o = '{
    rd_we: wb_q.rd_we,
    rd: wb_q.rd,
    data: wb_q.result
  };

  // retire trace
  // reset bubbles show up here as cycle_reset with zero pc and insn
  assign trace_o = '{
    pc: wb_q.pc,
    insn: wb_q.insn,
    status: wb_q.status
  };

endmodule

`default_nettype wire

//--- rv_pipeline_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_pipeline_top
  import rv_pipe_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  wire           clk,
  input  wire           rst,
  input  word_t         insn_i,
  output word_t         pc_o,
  output retire_trace_t trace_o,
  output wb_write_t     write_o
);

  // stage registers between the blocks
  dec_stage_t dec;
  exe_stage_t exe;
  mem_stage_t mem;

  // register file read ports
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;

  rv_fetch #(
    .reset_pc(reset_pc)
  ) u_fetch (
    .clk   (clk),
    .rst   (rst),
    .insn_i(insn_i),
    .pc_o  (pc_o),
    .dec_o (dec)
  );

  // write_o doubles as the register file write and the writeback bypass
  rv_regfile u_regfile (
    .clk       (clk),
    .rst       (rst),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .wr_i      (write_o)
  );

  rv_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .dec_i     (dec),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .exe_o     (exe)
  );

  rv_execute u_execute (
    .clk  (clk),
    .rst  (rst),
    .exe_i(exe),
    .wb_i (write_o),
    .mem_o(mem)
  );

  rv_writeback u_writeback (
    .clk    (clk),
    .rst    (rst),
    .mem_i  (mem),
    .wr_o   (write_o),
    .trace_o(trace_o)
  );

endmodule

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

// free-running testbench clock
module tb_clock #(
  parameter int period_ns = 4
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      // half a period per level
      #(period_ns / 2.0) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

//--- tb_rv_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_pipeline
  import rv_pipe_pkg::*;
();

  localparam word_t reset_pc = 32'h0000_0100;
  localparam word_t nop_insn = 32'h0000_0013;
  localparam int clk_period_ns = 4;
  localparam int reset_cycles = 8;
  // program lengths of the tests
  localparam int len_reset = 4;
  localparam int len_indep = 8;
  localparam int len_bypass = 12;
  localparam int len_zero = 6;
  localparam int len_random = 200;
  // reset, pipeline fill and first-retire wait per test
  localparam int test_overhead = 16;
  localparam int watchdog_cycles = len_reset + len_indep + len_bypass + len_zero
                                   + len_random + 5 * test_overhead + 50;

  logic          clk;
  logic          rst = 1'b1;
  word_t         insn = nop_insn;
  word_t         fetch_pc;
  retire_trace_t trace;
  wb_write_t     write;

  // program image and the expected retire of each slot
  word_t     prog [0:255];
  int        prog_len = 0;
  word_t     model_regs [0:31];
  word_t     exp_pc [0:255];
  word_t     exp_insn [0:255];
  logic      exp_we [0:255];
  logic [4:0] exp_rd [0:255];
  word_t     exp_data [0:255];
  int        errors = 0;
  int        checks = 0;
  logic [31:0] rng_state = 32'd18;

  tb_clock #(.period_ns(clk_period_ns)) u_clock (.clk_o(clk));

  rv_pipeline_top #(
    .reset_pc(reset_pc)
  ) DUT (
    .clk    (clk),
    .rst    (rst),
    .insn_i (insn),
    .pc_o   (fetch_pc),
    .trace_o(trace),
    .write_o(write)
  );

  // instruction memory lookup that returns a no-op outside the program
  function automatic word_t fetch_word(input word_t pc);
    word_t offset;
    offset = pc - reset_pc;
    if (offset[1:0] == 2'b00 && (offset >> 2) < word_t'(prog_len)) begin
      return prog[offset[9:2]];
    end
    return nop_insn;
  endfunction

  // next fetch pc is reset_pc while the DUT sees reset and pc + 4 otherwise
  always @(posedge clk) begin
    if (rst) begin
      insn <= fetch_word(reset_pc);
    end else begin
      insn <= fetch_word(fetch_pc + 32'd4);
    end
  end

  // rv32i encodings
  function automatic word_t encode_lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic word_t encode_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic word_t encode_add(input int rd, input int rs1, input int rs2);
    return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t encode_sub(input int rd, input int rs1, input int rs2);
    return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_insn(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // sequential ISA model stepping one instruction at a time in program order
  task automatic model_step(input int idx);
    word_t w;
    word_t a;
    word_t b;
    word_t result;
    logic [4:0] rd;
    logic writes;
    w = prog[idx];
    rd = w[11:7];
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    writes = 1'b1;
    result = '0;
    if (w[6:0] == 7'b0110111) begin
      result = {w[31:12], 12'h000};
    end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
      result = a + {{20{w[31]}}, w[31:20]};
    end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
      result = a + b;
    end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'h20) begin
      result = a - b;
    end else begin
      // anything else retires silently
      writes = 1'b0;
    end
    if (rd == 5'd0) writes = 1'b0;
    if (writes) model_regs[rd] = result;
    exp_pc[idx] = reset_pc + word_t'(idx << 2);
    exp_insn[idx] = w;
    exp_we[idx] = writes;
    exp_rd[idx] = rd;
    exp_data[idx] = result;
  endtask

  // compare the slot on the trace and write port against the model
  task automatic check_retire(input int idx);
    checks++;
    if (trace.status !== cycle_no_stall) begin
      errors++;
      $display("mismatch at %0t ns: trace.status expected %0d got %0d", $time,
               cycle_no_stall, trace.status);
    end
    if (trace.pc !== exp_pc[idx]) begin
      errors++;
      $display("mismatch at %0t ns: trace.pc expected %h got %h", $time, exp_pc[idx], trace.pc);
    end
    if (trace.insn !== exp_insn[idx]) begin
      errors++;
      $display("mismatch at %0t ns: trace.insn expected %h got %h", $time,
               exp_insn[idx], trace.insn);
    end
    if (write.rd_we !== exp_we[idx]) begin
      errors++;
      $display("mismatch at %0t ns: write.rd_we expected %b got %b", $time,
               exp_we[idx], write.rd_we);
    end
    if (exp_we[idx] && write.rd !== exp_rd[idx]) begin
      errors++;
      $display("mismatch at %0t ns: write.rd expected %0d got %0d", $time, exp_rd[idx], write.rd);
    end
    if (exp_we[idx] && write.data !== exp_data[idx]) begin
      errors++;
      $display("mismatch at %0t ns: write.data expected %h got %h", $time,
               exp_data[idx], write.data);
    end
  endtask

  // reset the DUT, run the loaded program and check every retire
  task automatic run_program(input string name);
    int resets_seen;
    int wait_cycles;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    for (int i = 0; i < prog_len; i++) model_step(i);
    @(posedge clk);
    rst <= 1'b1;
    for (int c = 0; c < reset_cycles; c++) begin
      @(posedge clk);
      // first sample still shows the cycle before reset took effect
      if (c > 0) begin
        checks++;
        if (fetch_pc !== reset_pc) begin
          errors++;
          $display("mismatch at %0t ns: pc_o expected %h got %h", $time, reset_pc, fetch_pc);
        end
        if (write.rd_we !== 1'b0) begin
          errors++;
          $display("mismatch at %0t ns: write.rd_we expected 0 got %b", $time, write.rd_we);
        end
      end
    end
    rst <= 1'b0;
    // this sample still belongs to the last reset edge
    @(posedge clk);
    resets_seen = 0;
    wait_cycles = 0;
    @(posedge clk);
    while (trace.status !== cycle_no_stall && wait_cycles < 20) begin
      if (trace.status === cycle_reset) begin
        resets_seen++;
      end else begin
        errors++;
        $display("%s: unexpected trace status %0d while waiting", name, trace.status);
      end
      wait_cycles++;
      @(posedge clk);
    end
    if (trace.status !== cycle_no_stall) begin
      errors++;
      $display("%s: no instruction retired after reset", name);
    end else begin
      // three bubbles pin the capture-to-retire latency at 3 cycles
      checks++;
      if (resets_seen != 3) begin
        errors++;
        $display("mismatch at %0t ns: reset bubbles expected 3 got %0d", $time, resets_seen);
      end
      for (int i = 0; i < prog_len; i++) begin
        if (i > 0) @(posedge clk);
        check_retire(i);
      end
    end
  endtask

  task automatic test_reset();
    prog_len = 0;
    add_insn(encode_addi(1, 0, 1));
    add_insn(encode_addi(2, 0, 2));
    add_insn(encode_addi(3, 0, 3));
    add_insn(encode_addi(4, 0, 4));
    run_program("reset");
  endtask

  task automatic test_independent();
    prog_len = 0;
    add_insn(encode_lui(1, 'h12345));
    add_insn(encode_addi(2, 0, -1));
    add_insn(encode_lui(3, 'hfffff));
    add_insn(encode_addi(4, 0, 'h7ff));
    add_insn(encode_addi(5, 0, -2048));
    add_insn(encode_lui(6, 1));
    add_insn(encode_addi(7, 0, 'h123));
    add_insn(encode_lui(8, 'h80000));
    run_program("independent");
  endtask

  task automatic test_bypass();
    prog_len = 0;
    add_insn(encode_addi(1, 0, 100));
    add_insn(encode_addi(2, 0, 7));
    // distance 2 and 1
    add_insn(encode_add(3, 1, 2));
    add_insn(encode_sub(4, 3, 2));
    // distance 3 goes through the register file write-through
    add_insn(encode_add(5, 2, 4));
    add_insn(encode_sub(6, 5, 3));
    add_insn(encode_add(7, 6, 6));
    add_insn(encode_addi(7, 7, -5));
    // the younger of two x7 producers in flight must win
    add_insn(encode_add(8, 7, 5));
    add_insn(encode_sub(9, 7, 8));
    add_insn(encode_lui(1, 'habcde));
    add_insn(encode_add(10, 1, 9));
    run_program("bypass");
  endtask

  task automatic test_zero();
    prog_len = 0;
    add_insn(encode_addi(1, 0, 55));
    add_insn(encode_addi(0, 1, 9));
    add_insn(encode_lui(0, 'h12345));
    // x0 read right behind two dropped x0 writes
    add_insn(encode_add(2, 0, 1));
    add_insn(encode_sub(3, 0, 2));
    add_insn(encode_add(0, 3, 3));
    run_program("zero");
  endtask

  task automatic test_random();
    logic [31:0] r;
    int kind;
    prog_len = 0;
    for (int i = 0; i < len_random; i++) begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      kind = int'(r % 32'd10);
      // only x0..x7 so that hazards are frequent
      case (kind)
        0, 1: add_insn(encode_lui(int'(r[10:8]), int'(r[31:12])));
        2, 3, 4: add_insn(encode_addi(int'(r[10:8]), int'(r[13:11]), int'(r[31:20])));
        5, 6: add_insn(encode_add(int'(r[10:8]), int'(r[13:11]), int'(r[16:14])));
        7, 8: add_insn(encode_sub(int'(r[10:8]), int'(r[13:11]), int'(r[16:14])));
        default: begin
          // xori, load, branch or mul
          case (r[18:17])
            2'd0: add_insn({r[31:15], 3'b100, r[11:7], 7'b0010011});
            2'd1: add_insn({r[31:7], 7'b0000011});
            2'd2: add_insn({r[31:7], 7'b1100011});
            default: add_insn({7'b0000001, r[24:15], 3'b000, r[11:7], 7'b0110011});
          endcase
        end
      endcase
    end
    run_program("random");
  endtask

  // bound on the whole run
  initial begin
    #(watchdog_cycles * clk_period_ns);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    $timeformat(-9, 0, "", 0);
    test_reset();
    test_independent();
    test_bypass();
    test_zero();
    test_random();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rv_pipe_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_writeback.sv
rv_pipeline_top.sv
tb_clock.sv
tb_rv_pipeline.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/10ps -j 0
TOP       := tb_rv_pipeline
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
